// File: src/mem_pkg.sv
package mem_pkg;

	typedef logic [31:0]  addr_t;  // byte address
	typedef logic [255:0] line_t;  // one cache line of 8 words

	localparam int LINE_BYTES  = 32;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);

	// line number is the byte address without its offset bits
	typedef logic [$bits(addr_t)-OFFSET_BITS-1:0] line_addr_t;

	function automatic line_addr_t line_of(input addr_t addr);
		return addr[$bits(addr_t)-1:OFFSET_BITS];
	endfunction

endpackage : mem_pkg

// File: src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic            clk,
	input  logic            rst,

	input  logic            i_instr_read,
	input  mem_pkg::addr_t  i_instr_addr,
	output logic            o_instr_resp,
	output mem_pkg::line_t  o_instr_rdata,

	input  logic            i_lsq_read,
	input  logic            i_lsq_write,
	input  mem_pkg::addr_t  i_lsq_addr,
	input  mem_pkg::line_t  i_lsq_wdata,
	output logic            o_lsq_resp,
	output mem_pkg::line_t  o_lsq_rdata,

	input  logic            i_pref_read,
	input  mem_pkg::addr_t  i_pref_addr,
	output logic            o_pref_resp,
	output mem_pkg::line_t  o_pref_rdata,

	input  logic            i_mem_resp,
	input  mem_pkg::line_t  i_mem_rdata,
	output logic            o_mem_read,
	output logic            o_mem_write,
	output mem_pkg::addr_t  o_mem_addr,
	output mem_pkg::line_t  o_mem_wdata,

	output logic            o_idle
);

	import mem_pkg::*;

	typedef enum logic [1:0] {
		idle,
		serve_instr,
		serve_lsq,
		serve_pref
	} arb_state_t;

	arb_state_t state;
	arb_state_t next_state;

	logic lsq_req;

	assign lsq_req = i_lsq_read | i_lsq_write;
	assign o_idle  = (state == idle);

	// the served port is routed to memory and every other port sees zero
	always_comb begin
		o_instr_resp  = 1'b0;
		o_instr_rdata = '0;
		o_lsq_resp    = 1'b0;
		o_lsq_rdata   = '0;
		o_pref_resp   = 1'b0;
		o_pref_rdata  = '0;
		o_mem_read    = 1'b0;
		o_mem_write   = 1'b0;
		o_mem_addr    = '0;
		o_mem_wdata   = '0;
		unique case (state)
			idle: ;
			serve_instr: begin
				o_instr_resp  = i_mem_resp;
				o_instr_rdata = i_mem_rdata;
				o_mem_read    = i_instr_read;
				o_mem_addr    = i_instr_addr;
			end
			serve_lsq: begin
				o_lsq_resp  = i_mem_resp;
				o_lsq_rdata = i_mem_rdata;
				o_mem_read  = i_lsq_read;
				o_mem_write = i_lsq_write;
				o_mem_addr  = i_lsq_addr;
				o_mem_wdata = i_lsq_wdata;
			end
			serve_pref: begin
				o_pref_resp  = i_mem_resp;
				o_pref_rdata = i_mem_rdata;
				o_mem_read   = i_pref_read;
				o_mem_addr   = i_pref_addr;
			end
		endcase
	end

	always_comb begin
		next_state = state;
		unique case (state)
			idle: begin
				if (i_instr_read)
					next_state = serve_instr;
				else if (lsq_req)
					next_state = serve_lsq;
				else if (i_pref_read)
					next_state = serve_pref;
			end
			serve_instr: begin
				if (i_mem_resp)
					next_state = lsq_req ? serve_lsq : idle;  // waiting lsq skips idle
			end
			serve_lsq: begin
				if (i_mem_resp)
					next_state = i_instr_read ? serve_instr : idle;
			end
			serve_pref: begin
				if (i_mem_resp) begin
					if (i_instr_read)
						next_state = serve_instr;
					else if (lsq_req)
						next_state = serve_lsq;
					else
						next_state = idle;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// memory answers only a request that is granted and still held
	a_one_resp: assert property (@(posedge clk) disable iff (rst)
		i_mem_resp |-> !o_idle && (o_mem_read || o_mem_write));

	// requester holds its request and address until the memory answers
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		!o_idle && !i_mem_resp |=> (o_mem_read || o_mem_write) && $stable(o_mem_addr));

endmodule : mem_arbiter

// File: src/next_line_prefetcher.sv
`timescale 1ns/1ps

module next_line_prefetcher (
	input  logic            clk,
	input  logic            rst,

	input  logic            i_ic_read,
	input  mem_pkg::addr_t  i_ic_addr,
	output logic            o_ic_resp,
	output mem_pkg::line_t  o_ic_rdata,

	input  logic            i_lsq_write,
	input  mem_pkg::addr_t  i_lsq_addr,

	output logic            o_arb_instr_read,
	output mem_pkg::addr_t  o_arb_instr_addr,
	input  logic            i_arb_instr_resp,
	input  mem_pkg::line_t  i_arb_instr_rdata,

	output logic            o_arb_pref_read,
	output mem_pkg::addr_t  o_arb_pref_addr,
	input  logic            i_arb_pref_resp,
	input  mem_pkg::line_t  i_arb_pref_rdata
);

	import mem_pkg::*;

	typedef enum logic {
		pf_idle,
		pf_busy
	} pf_state_t;

	pf_state_t  pf_state;
	logic       pf_discard;  // line being fetched was written meanwhile
	addr_t      pf_addr;

	logic       buf_valid;
	line_addr_t buf_tag;
	line_t      buf_data;

	logic       hit_resp_q;
	line_t      hit_data_q;
	logic       miss_active;

	logic       wr_hits_buf;
	logic       wr_hits_pf;
	logic       wr_hits_next;
	logic       buf_hit;
	logic       ic_new;
	logic       hit_take;
	logic       miss_take;
	logic       pf_start;
	logic       pf_fill;
	addr_t      next_addr;

	assign next_addr = addr_t'({line_of(i_ic_addr), {OFFSET_BITS{1'b0}}}) + addr_t'(LINE_BYTES);

	assign wr_hits_buf  = i_lsq_write && buf_valid && (line_of(i_lsq_addr) == buf_tag);
	assign wr_hits_pf   = i_lsq_write && (line_of(i_lsq_addr) == line_of(pf_addr));
	assign wr_hits_next = i_lsq_write && (line_of(i_lsq_addr) == line_of(next_addr));
	assign buf_hit      = buf_valid && (line_of(i_ic_addr) == buf_tag) && !wr_hits_buf;

	// a request is new unless a miss is in flight or its hit answer is out now
	assign ic_new    = i_ic_read && !miss_active && !hit_resp_q;
	assign hit_take  = ic_new && buf_hit;
	assign miss_take = ic_new && !buf_hit;
	assign pf_start  = i_arb_instr_resp && (pf_state == pf_idle);
	assign pf_fill   = i_arb_pref_resp && !pf_discard && !wr_hits_pf;

	assign o_arb_instr_read = miss_active || miss_take;
	assign o_arb_instr_addr = i_ic_addr;
	assign o_arb_pref_read  = (pf_state == pf_busy);
	assign o_arb_pref_addr  = pf_addr;

	assign o_ic_resp  = hit_resp_q | i_arb_instr_resp;
	assign o_ic_rdata = hit_resp_q ? hit_data_q : i_arb_instr_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_resp_q  <= 1'b0;
			miss_active <= 1'b0;
			pf_state    <= pf_idle;
			pf_discard  <= 1'b0;
			buf_valid   <= 1'b0;
		end else begin
			hit_resp_q <= hit_take;
			if (i_arb_instr_resp)
				miss_active <= 1'b0;
			else if (miss_take)
				miss_active <= 1'b1;
			unique case (pf_state)
				pf_idle: begin
					if (pf_start) begin
						pf_state   <= pf_busy;
						pf_discard <= wr_hits_next;
					end
				end
				pf_busy: begin
					if (i_arb_pref_resp)
						pf_state <= pf_idle;
					else if (wr_hits_pf)
						pf_discard <= 1'b1;
				end
			endcase
			if (pf_fill)
				buf_valid <= 1'b1;  // fill replaces whatever line was held
			else if (wr_hits_buf)
				buf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pf_start)
			pf_addr <= next_addr;
		if (pf_fill) begin
			buf_tag  <= line_of(pf_addr);
			buf_data <= i_arb_pref_rdata;
		end
		if (hit_take)
			hit_data_q <= buf_data;
	end

	// a prefetch response only comes while the prefetch is outstanding
	a_pf_resp: assert property (@(posedge clk) disable iff (rst)
		i_arb_pref_resp |-> o_arb_pref_read);

endmodule : next_line_prefetcher

// File: src/line_memory.sv
`timescale 1ns/1ps

module line_memory #(
	parameter int MEM_LINES   = 256,
	parameter int MEM_LATENCY = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_read,
	input  logic            i_write,
	input  mem_pkg::addr_t  i_addr,
	input  mem_pkg::line_t  i_wdata,
	output logic            o_resp,
	output mem_pkg::line_t  o_rdata
);

	import mem_pkg::*;

	localparam int IDX_BITS = $clog2(MEM_LINES);
	localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

	typedef logic [IDX_BITS-1:0] idx_t;
	typedef logic [CNT_BITS-1:0] cnt_t;

	line_t mem [MEM_LINES];

	logic  busy;
	cnt_t  cnt;  // cycles since the request was taken
	logic  wr_q;
	idx_t  idx_q;
	line_t wdata_q;

	assign o_resp  = busy && (cnt == cnt_t'(MEM_LATENCY));
	assign o_rdata = o_resp ? mem[idx_q] : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (!busy && (i_read || i_write)) begin
			busy <= 1'b1;
			cnt  <= cnt_t'(1);
		end else if (o_resp) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt + cnt_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && (i_read || i_write)) begin
			wr_q    <= i_write;
			idx_q   <= i_addr[OFFSET_BITS +: IDX_BITS];
			wdata_q <= i_wdata;
		end
	end

	// the write lands on the edge that ends the response cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_LINES; i++)
				mem[i] <= '0;
		end else if (o_resp && wr_q) begin
			mem[idx_q] <= wdata_q;
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(i_read && i_write));

endmodule : line_memory

// File: src/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
	parameter int MEM_LINES   = 256,
	parameter int MEM_LATENCY = 4
) (
	input  logic            clk,
	input  logic            rst,

	input  logic            i_ic_read,
	input  mem_pkg::addr_t  i_ic_addr,
	output logic            o_ic_resp,
	output mem_pkg::line_t  o_ic_rdata,

	input  logic            i_lsq_read,
	input  logic            i_lsq_write,
	input  mem_pkg::addr_t  i_lsq_addr,
	input  mem_pkg::line_t  i_lsq_wdata,
	output logic            o_lsq_resp,
	output mem_pkg::line_t  o_lsq_rdata,

	output logic            o_mem_idle
);

	import mem_pkg::*;

	logic  instr_read;
	addr_t instr_addr;
	logic  instr_resp;
	line_t instr_rdata;

	logic  pref_read;
	addr_t pref_addr;
	logic  pref_resp;
	line_t pref_rdata;

	logic  mem_read;
	logic  mem_write;
	addr_t mem_addr;
	line_t mem_wdata;
	logic  mem_resp;
	line_t mem_rdata;

	next_line_prefetcher u_prefetcher (
		.clk               (clk),
		.rst               (rst),
		.i_ic_read         (i_ic_read),
		.i_ic_addr         (i_ic_addr),
		.o_ic_resp         (o_ic_resp),
		.o_ic_rdata        (o_ic_rdata),
		.i_lsq_write       (i_lsq_write),
		.i_lsq_addr        (i_lsq_addr),
		.o_arb_instr_read  (instr_read),
		.o_arb_instr_addr  (instr_addr),
		.i_arb_instr_resp  (instr_resp),
		.i_arb_instr_rdata (instr_rdata),
		.o_arb_pref_read   (pref_read),
		.o_arb_pref_addr   (pref_addr),
		.i_arb_pref_resp   (pref_resp),
		.i_arb_pref_rdata  (pref_rdata)
	);

	mem_arbiter u_arbiter (
		.clk           (clk),
		.rst           (rst),
		.i_instr_read  (instr_read),
		.i_instr_addr  (instr_addr),
		.o_instr_resp  (instr_resp),
		.o_instr_rdata (instr_rdata),
		.i_lsq_read    (i_lsq_read),
		.i_lsq_write   (i_lsq_write),
		.i_lsq_addr    (i_lsq_addr),
		.i_lsq_wdata   (i_lsq_wdata),
		.o_lsq_resp    (o_lsq_resp),
		.o_lsq_rdata   (o_lsq_rdata),
		.i_pref_read   (pref_read),
		.i_pref_addr   (pref_addr),
		.o_pref_resp   (pref_resp),
		.o_pref_rdata  (pref_rdata),
		.i_mem_resp    (mem_resp),
		.i_mem_rdata   (mem_rdata),
		.o_mem_read    (mem_read),
		.o_mem_write   (mem_write),
		.o_mem_addr    (mem_addr),
		.o_mem_wdata   (mem_wdata),
		.o_idle        (o_mem_idle)
	);

	line_memory #(
		.MEM_LINES   (MEM_LINES),
		.MEM_LATENCY (MEM_LATENCY)
	) u_memory (
		.clk     (clk),
		.rst     (rst),
		.i_read  (mem_read),
		.i_write (mem_write),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_resp  (mem_resp),
		.o_rdata (mem_rdata)
	);

endmodule : mem_subsystem_top

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

	import mem_pkg::*;

	localparam int MEM_LINES       = 256;
	localparam int MEM_LATENCY     = 4;
	localparam int IDX_BITS        = $clog2(MEM_LINES);
	localparam int ROUNDS          = 8;
	localparam int REQS_PER_ROUND  = 9;
	localparam int WATCHDOG_CYCLES = 3 + ROUNDS * REQS_PER_ROUND * 200 * (MEM_LATENCY + 2);

	typedef logic [IDX_BITS-1:0] idx_t;

	logic  clk = 1'b0;
	logic  rst;
	logic  ic_read;
	addr_t ic_addr;
	logic  ic_resp;
	line_t ic_rdata;
	logic  lsq_read;
	logic  lsq_write;
	addr_t lsq_addr;
	line_t lsq_wdata;
	logic  lsq_resp;
	line_t lsq_rdata;
	logic  mem_idle;

	logic [31:0] lfsr = 32'hb7ed5b65;
	line_t       shadow [MEM_LINES];
	line_t       exp_ic;
	line_t       exp_lsq;

	always #50 clk = ~clk;

	mem_subsystem_top #(
		.MEM_LINES   (MEM_LINES),
		.MEM_LATENCY (MEM_LATENCY)
	) DUT (
		.clk         (clk),
		.rst         (rst),
		.i_ic_read   (ic_read),
		.i_ic_addr   (ic_addr),
		.o_ic_resp   (ic_resp),
		.o_ic_rdata  (ic_rdata),
		.i_lsq_read  (lsq_read),
		.i_lsq_write (lsq_write),
		.i_lsq_addr  (lsq_addr),
		.i_lsq_wdata (lsq_wdata),
		.o_lsq_resp  (lsq_resp),
		.o_lsq_rdata (lsq_rdata),
		.o_mem_idle  (mem_idle)
	);

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic show_mismatch(input string name, input line_t expected, input line_t actual);
		$display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
		abort_run();
	endtask

	task automatic explain_error(input string what);
		$display("%0t: %s", $time, what);
		abort_run();
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
	endfunction

	task automatic draw_bits(input int n, output line_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[254:0], lfsr[0]};
		end
	endtask

	// lines stop one short of the top so that the next line still exists
	task automatic choose_line(input int avoid, output int line);
		line_t v;
		draw_bits(IDX_BITS, v);
		line = int'(v[IDX_BITS-1:0]) % (MEM_LINES - 1);
		if (line == avoid)
			line = (line + 1) % (MEM_LINES - 1);
	endtask

	task automatic random_data(output line_t data);
		draw_bits(256, data);
	endtask

	function automatic idx_t shadow_index(input addr_t a);
		return idx_t'(a / addr_t'(LINE_BYTES));
	endfunction

	function automatic addr_t addr_of_line(input int line);
		return addr_t'(line) * addr_t'(LINE_BYTES);
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_LINES; i++)
				shadow[i] <= '0;
		end else if (lsq_resp && lsq_write) begin
			shadow[shadow_index(lsq_addr)] <= lsq_wdata;
		end
	end

	assign exp_ic  = shadow[shadow_index(ic_addr)];
	assign exp_lsq = shadow[shadow_index(lsq_addr)];

	ic_data_ok: assert property (@(posedge clk) disable iff (rst)
		ic_resp |-> ic_rdata == exp_ic)
		else show_mismatch("o_ic_rdata", $sampled(exp_ic), $sampled(ic_rdata));

	lsq_data_ok: assert property (@(posedge clk) disable iff (rst)
		lsq_resp && lsq_read |-> lsq_rdata == exp_lsq)
		else show_mismatch("o_lsq_rdata", $sampled(exp_lsq), $sampled(lsq_rdata));

	reset_state_ok: assert property (@(posedge clk)
		$fell(rst) |-> mem_idle && !ic_resp && !lsq_resp)
		else explain_error("the DUT was not idle with quiet responses right after reset");

	// cycles counts edges from the request edge to the response cycle
	task automatic ic_access(input int line, output int cycles);
		@(posedge clk);
		ic_read <= 1'b1;
		ic_addr <= addr_of_line(line);
		cycles = 0;
		@(negedge clk);
		while (!ic_resp) begin
			@(negedge clk);
			cycles++;
		end
		@(posedge clk);
		ic_read <= 1'b0;
	endtask

	task automatic lsq_access(input logic write, input int line, input line_t data,
			output int cycles);
		@(posedge clk);
		lsq_read  <= !write;
		lsq_write <= write;
		lsq_addr  <= addr_of_line(line);
		lsq_wdata <= data;
		cycles = 0;
		@(negedge clk);
		while (!lsq_resp) begin
			@(negedge clk);
			cycles++;
		end
		@(posedge clk);
		lsq_read  <= 1'b0;
		lsq_write <= 1'b0;
	endtask

	// waits for two idle cycles in a row because idle shows for one cycle before a prefetch grant
	task automatic wait_settled();
		int cycles;
		int run;
		cycles = 0;
		run = 0;
		while (run < 2) begin
			@(negedge clk);
			cycles++;
			run = mem_idle ? run + 1 : 0;
		end
		assert (cycles - 1 <= 1 + 2 * MEM_LATENCY)
			else explain_error($sformatf("o_mem_idle took %0d cycles to return", cycles - 1));
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		explain_error("watchdog expired before all requests were answered");
	end

	initial begin
		int    a;
		int    b;
		int    c;
		int    e;
		int    cycles;
		int    ic_cycles;
		int    lsq_cycles;
		line_t data;
		rst       <= 1'b1;
		ic_read   <= 1'b0;
		ic_addr   <= '0;
		lsq_read  <= 1'b0;
		lsq_write <= 1'b0;
		lsq_addr  <= '0;
		lsq_wdata <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < ROUNDS; r++) begin
			choose_line(-1, a);
			random_data(data);
			lsq_access(1'b1, a, data, cycles);
			wait_settled();
			lsq_access(1'b0, a, '0, cycles);
			wait_settled();
			ic_access(a, cycles);  // the write above dropped any buffered copy of a
			assert (cycles <= 1 + MEM_LATENCY)
				else explain_error($sformatf("instruction miss took %0d cycles", cycles));
			wait_settled();
			ic_access(a + 1, cycles);
			assert (cycles == 1)
				else show_mismatch("o_ic_resp delay", line_t'(1), line_t'(cycles));
			wait_settled();
			choose_line(a + 1, b);
			choose_line(-1, c);
			fork
				ic_access(b, ic_cycles);
				lsq_access(1'b0, c, '0, lsq_cycles);
			join
			assert (ic_cycles < lsq_cycles)
				else explain_error("the load/store response came before the instruction one");
			wait_settled();
			choose_line(b + 1, e);
			ic_access(e, cycles);
			wait_settled();
			random_data(data);
			lsq_access(1'b1, e + 1, data, cycles);  // hits the freshly prefetched line
			wait_settled();
			ic_access(e + 1, cycles);
			wait_settled();
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule : tb_mem_subsystem

// File: project.f
src/mem_pkg.sv
src/mem_arbiter.sv
src/next_line_prefetcher.sv
src/line_memory.sv
src/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# build the Verilator model, run it, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mem_subsystem -f project.f -o tb_sim \
	|| exit 1
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulation exited with an error status" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || grep -q "RESULT: PASS" sim.log
